//--- csr_defs.svh
`ifndef CSR_DEFS_SVH
`define CSR_DEFS_SVH

// Register width of the hart
`define CSR_XLEN 32

// Machine identity, read-only
`define CSR_ADDR_MVENDORID     12'hF11
`define CSR_ADDR_MARCHID       12'hF12
`define CSR_ADDR_MIMPID        12'hF13
`define CSR_ADDR_MHARTID       12'hF14

// Machine trap setup
`define CSR_ADDR_MSTATUS       12'h300
`define CSR_ADDR_MISA          12'h301
`define CSR_ADDR_MIE           12'h304
`define CSR_ADDR_MTVEC         12'h305
`define CSR_ADDR_MCOUNTINHIBIT 12'h320

// Machine trap handling
`define CSR_ADDR_MSCRATCH      12'h340
`define CSR_ADDR_MEPC          12'h341
`define CSR_ADDR_MCAUSE        12'h342
`define CSR_ADDR_MTVAL         12'h343
`define CSR_ADDR_MIP           12'h344

// Machine counters
`define CSR_ADDR_MCYCLE        12'hB00
`define CSR_ADDR_MINSTRET      12'hB02
`define CSR_ADDR_MCYCLEH       12'hB80
`define CSR_ADDR_MINSTRETH     12'hB82

// MXL = 1 (RV32), I extension only
`define CSR_MISA_VALUE 32'h4000_0100

// mcountinhibit bit positions
`define CSR_CY_BIT 0
`define CSR_IR_BIT 2

`endif // CSR_DEFS_SVH

//--- csr_pkg.sv
`include "csr_defs.svh"

package csr_pkg;

  // Address fields as laid out by the privileged spec
  typedef struct packed {
    logic [1:0] access; // 3 marks a read-only CSR
    logic [1:0] priv;   // Lowest privilege allowed to access
    logic [7:0] num;
  } csr_addr_fields_t;

  // Same 12 bits, seen as a flat number or split into fields
  typedef union packed {
    logic [11:0]      raw;
    csr_addr_fields_t fields;
  } csr_addr_u;

  typedef enum logic [1:0] {
    CSR_OP_WRITE = 2'd0,
    CSR_OP_SET   = 2'd1,
    CSR_OP_CLEAR = 2'd2
  } csr_op_e;

  typedef struct packed {
    csr_op_e               op;
    csr_addr_u             addr;
    logic [`CSR_XLEN-1:0]  data;
  } csr_req_t;

  typedef struct packed {
    logic [`CSR_XLEN-1:0] data;    // Value before the write
    logic                 exists;
    logic                 illegal; // Unknown CSR or write to read-only
  } csr_resp_t;

  // One pipeline side effect per cycle
  typedef enum logic [1:0] {
    EFF_NONE    = 2'd0,
    EFF_INSTRET = 2'd1,
    EFF_TRAP    = 2'd2,
    EFF_MRET    = 2'd3
  } csr_eff_e;

  typedef struct packed {
    csr_eff_e             kind;
    logic [`CSR_XLEN-1:0] epc;
    logic [`CSR_XLEN-1:0] cause;
    logic [`CSR_XLEN-1:0] tval;
  } csr_effect_t;

  // Write port from the access block to the register blocks
  typedef struct packed {
    logic                 en;
    logic [11:0]          addr;
    logic [`CSR_XLEN-1:0] data;
  } csr_wr_t;

endpackage

//--- csr_trap_regs.sv
`timescale 1ns/1ns
`include "csr_defs.svh"

module csr_trap_regs (
  input  logic                 clk,
  input  logic                 rst,
  input  csr_pkg::csr_wr_t     wr,
  input  csr_pkg::csr_effect_t effect,
  input  csr_pkg::csr_addr_u   rd_addr,
  output logic [`CSR_XLEN-1:0] rd_data,
  output logic                 rd_hit,
  output logic [`CSR_XLEN-1:0] trap_vector,
  output logic [`CSR_XLEN-1:0] epc_out,
  output logic                 irq_enable
);

  // mstatus, only the global interrupt enable pair
  logic status_mie;
  logic status_mpie;

  // mie enables
  logic msie;
  logic mtie;
  logic meie;

  logic [`CSR_XLEN-1:0] mtvec; // Direct mode only
  logic [`CSR_XLEN-1:0] mscratch;
  logic [`CSR_XLEN-1:0] mepc;
  logic [`CSR_XLEN-1:0] mcause;
  logic [`CSR_XLEN-1:0] mtval;

  logic [`CSR_XLEN-1:0] mstatus_word;
  logic [`CSR_XLEN-1:0] mie_word;

  always_comb begin
    mstatus_word    = '0;
    mstatus_word[7] = status_mpie;
    mstatus_word[3] = status_mie;
    mie_word        = '0;
    mie_word[11]    = meie;
    mie_word[7]     = mtie;
    mie_word[3]     = msie;
  end

  // Read decode
  always_comb begin
    rd_hit  = 1'b1;
    rd_data = '0;
    case (rd_addr.raw)
      `CSR_ADDR_MSTATUS:  rd_data = mstatus_word;
      `CSR_ADDR_MIE:      rd_data = mie_word;
      `CSR_ADDR_MTVEC:    rd_data = mtvec;
      `CSR_ADDR_MSCRATCH: rd_data = mscratch;
      `CSR_ADDR_MEPC:     rd_data = mepc;
      `CSR_ADDR_MCAUSE:   rd_data = mcause;
      `CSR_ADDR_MTVAL:    rd_data = mtval;
      `CSR_ADDR_MIP:      rd_data = '0; // No pending logic
      default:            rd_hit  = 1'b0;
    endcase
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      status_mie  <= 1'b0;
      status_mpie <= 1'b0;
      msie        <= 1'b0;
      mtie        <= 1'b0;
      meie        <= 1'b0;
      mtvec       <= '0;
      mscratch    <= '0;
      mepc        <= '0;
      mcause      <= '0;
      mtval       <= '0;
    end else begin
      // Pipeline effects first; a CSR write further down overrides them
      case (effect.kind)
        csr_pkg::EFF_TRAP: begin
          mepc        <= effect.epc;
          mcause      <= effect.cause;
          mtval       <= effect.tval;
          status_mpie <= status_mie;
          status_mie  <= 1'b0; // Handler starts with interrupts off
        end
        csr_pkg::EFF_MRET: begin
          status_mie  <= status_mpie;
          status_mpie <= 1'b1;
        end
        default: ;
      endcase

      if (wr.en) begin
        case (wr.addr)
          `CSR_ADDR_MSTATUS: begin
            status_mpie <= wr.data[7];
            status_mie  <= wr.data[3];
          end
          `CSR_ADDR_MIE: begin
            meie <= wr.data[11];
            mtie <= wr.data[7];
            msie <= wr.data[3];
          end
          `CSR_ADDR_MTVEC:    mtvec    <= {wr.data[`CSR_XLEN-1:2], 2'b00};
          `CSR_ADDR_MSCRATCH: mscratch <= wr.data;
          `CSR_ADDR_MEPC:     mepc     <= wr.data;
          `CSR_ADDR_MCAUSE:   mcause   <= wr.data;
          `CSR_ADDR_MTVAL:    mtval    <= wr.data;
          default: ;
        endcase
      end
    end
  end

  assign trap_vector = mtvec;
  assign epc_out     = mepc;
  assign irq_enable  = status_mie;

  // Trap base stays word aligned whatever software writes
  a_mtvec_aligned: assert property (
    @(posedge clk) disable iff (rst) trap_vector[1:0] == 2'b00
  );

endmodule

//--- csr_counters.sv
`timescale 1ns/1ns
`include "csr_defs.svh"

module csr_counters (
  input  logic                 clk,
  input  logic                 rst,
  input  csr_pkg::csr_wr_t     wr,
  input  logic                 instret_pulse,
  input  csr_pkg::csr_addr_u   rd_addr,
  output logic [`CSR_XLEN-1:0] rd_data,
  output logic                 rd_hit
);

  logic [2*`CSR_XLEN-1:0] cycle;
  logic [2*`CSR_XLEN-1:0] instret;
  logic [`CSR_XLEN-1:0]   countinhibit; // Only CY and IR are implemented

  logic cy_inh;
  logic ir_inh;
  logic wr_cycle_lo;
  logic wr_cycle_hi;
  logic wr_instret_lo;
  logic wr_instret_hi;

  assign cy_inh = countinhibit[`CSR_CY_BIT];
  assign ir_inh = countinhibit[`CSR_IR_BIT];

  assign wr_cycle_lo   = wr.en && (wr.addr == `CSR_ADDR_MCYCLE);
  assign wr_cycle_hi   = wr.en && (wr.addr == `CSR_ADDR_MCYCLEH);
  assign wr_instret_lo = wr.en && (wr.addr == `CSR_ADDR_MINSTRET);
  assign wr_instret_hi = wr.en && (wr.addr == `CSR_ADDR_MINSTRETH);

  always_comb begin
    rd_hit  = 1'b1;
    rd_data = '0;
    case (rd_addr.raw)
      `CSR_ADDR_MCYCLE:        rd_data = cycle[`CSR_XLEN-1:0];
      `CSR_ADDR_MCYCLEH:       rd_data = cycle[2*`CSR_XLEN-1:`CSR_XLEN];
      `CSR_ADDR_MINSTRET:      rd_data = instret[`CSR_XLEN-1:0];
      `CSR_ADDR_MINSTRETH:     rd_data = instret[2*`CSR_XLEN-1:`CSR_XLEN];
      `CSR_ADDR_MCOUNTINHIBIT: rd_data = countinhibit;
      default:                 rd_hit  = 1'b0;
    endcase
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      cycle        <= '0;
      instret      <= '0;
      countinhibit <= '0;
    end else begin
      // Software write replaces one half and skips the increment
      if (wr_cycle_lo)
        cycle[`CSR_XLEN-1:0] <= wr.data;
      else if (wr_cycle_hi)
        cycle[2*`CSR_XLEN-1:`CSR_XLEN] <= wr.data;
      else if (!cy_inh)
        cycle <= cycle + 1'b1;

      if (wr_instret_lo)
        instret[`CSR_XLEN-1:0] <= wr.data;
      else if (wr_instret_hi)
        instret[2*`CSR_XLEN-1:`CSR_XLEN] <= wr.data;
      else if (instret_pulse && !ir_inh)
        instret <= instret + 1'b1;

      if (wr.en && wr.addr == `CSR_ADDR_MCOUNTINHIBIT) begin
        countinhibit[`CSR_CY_BIT] <= wr.data[`CSR_CY_BIT];
        countinhibit[`CSR_IR_BIT] <= wr.data[`CSR_IR_BIT];
      end
    end
  end

  // Inhibited cycle counter only moves through a software write
  a_cycle_inhibit: assert property (
    @(posedge clk) disable iff (rst)
      (cy_inh && !wr_cycle_lo && !wr_cycle_hi) |=> $stable(cycle)
  );

endmodule

//--- csr_access.sv
`timescale 1ns/1ns
`include "csr_defs.svh"

module csr_access (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 req_valid,
  input  csr_pkg::csr_req_t    req,
  output logic                 req_ready,
  output logic                 resp_valid,
  input  logic                 resp_ready,
  output csr_pkg::csr_resp_t   resp,
  output csr_pkg::csr_addr_u   rd_addr,
  input  logic [`CSR_XLEN-1:0] trap_data,
  input  logic                 trap_hit,
  input  logic [`CSR_XLEN-1:0] cnt_data,
  input  logic                 cnt_hit,
  output csr_pkg::csr_wr_t     wr
);

  logic                 accept;
  logic                 is_ident;
  logic                 is_misa;
  logic                 exists;
  logic                 read_only;
  logic                 wants_write;
  logic                 illegal;
  logic [`CSR_XLEN-1:0] rd_val;
  logic [`CSR_XLEN-1:0] new_val;
  csr_pkg::csr_resp_t   resp_next;

  assign rd_addr   = req.addr; // Both blocks look up the same address
  assign req_ready = !resp_valid || resp_ready;
  assign accept    = req_valid && req_ready;

  // Constant CSRs handled here
  always_comb begin
    is_ident = 1'b0;
    is_misa  = 1'b0;
    case (req.addr.raw)
      `CSR_ADDR_MVENDORID,
      `CSR_ADDR_MARCHID,
      `CSR_ADDR_MIMPID,
      `CSR_ADDR_MHARTID: is_ident = 1'b1;
      `CSR_ADDR_MISA:    is_misa  = 1'b1;
      default: ;
    endcase
  end

  assign exists = is_ident || is_misa || trap_hit || cnt_hit;

  always_comb begin
    if (is_misa)
      rd_val = `CSR_MISA_VALUE;
    else if (trap_hit)
      rd_val = trap_data;
    else if (cnt_hit)
      rd_val = cnt_data;
    else
      rd_val = '0; // Identity CSRs and unknown addresses
  end

  always_comb begin
    case (req.op)
      csr_pkg::CSR_OP_WRITE: new_val = req.data;
      csr_pkg::CSR_OP_SET:   new_val = rd_val | req.data;
      csr_pkg::CSR_OP_CLEAR: new_val = rd_val & ~req.data;
      default:               new_val = rd_val;
    endcase
  end

  // Set or clear with a zero mask is a pure read, as with rs1 = x0
  assign wants_write = (req.op == csr_pkg::CSR_OP_WRITE) || (req.data != '0);
  assign read_only   = (req.addr.fields.access == 2'b11);
  assign illegal     = !exists || (read_only && wants_write);

  assign wr.en   = accept && exists && !read_only && wants_write;
  assign wr.addr = req.addr.raw;
  assign wr.data = new_val;

  always_comb begin
    resp_next.data    = rd_val;
    resp_next.exists  = exists;
    resp_next.illegal = illegal;
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst)
      resp_valid <= 1'b0;
    else if (accept)
      resp_valid <= 1'b1;
    else if (resp_ready)
      resp_valid <= 1'b0;
  end

  // Loaded only on acceptance, so it holds under back-pressure
  always_ff @(posedge clk) begin
    if (accept)
      resp <= resp_next;
  end

  a_resp_stable: assert property (
    @(posedge clk) disable iff (rst)
      (resp_valid && !resp_ready) |=> $stable(resp)
  );

endmodule

//--- csr_unit.sv
`timescale 1ns/1ns
`include "csr_defs.svh"

module csr_unit (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 req_valid,
  input  csr_pkg::csr_req_t    req,
  output logic                 req_ready,
  output logic                 resp_valid,
  output csr_pkg::csr_resp_t   resp,
  input  logic                 resp_ready,
  input  csr_pkg::csr_effect_t effect,
  output logic [`CSR_XLEN-1:0] trap_vector,
  output logic [`CSR_XLEN-1:0] epc_out,
  output logic                 irq_enable
);

  csr_pkg::csr_addr_u   rd_addr;
  csr_pkg::csr_wr_t     wr;
  logic [`CSR_XLEN-1:0] trap_data;
  logic                 trap_hit;
  logic [`CSR_XLEN-1:0] cnt_data;
  logic                 cnt_hit;
  logic                 instret_pulse;

  assign instret_pulse = (effect.kind == csr_pkg::EFF_INSTRET);

  csr_access u_access (
    .clk        (clk),
    .rst        (rst),
    .req_valid  (req_valid),
    .req        (req),
    .req_ready  (req_ready),
    .resp_valid (resp_valid),
    .resp_ready (resp_ready),
    .resp       (resp),
    .rd_addr    (rd_addr),
    .trap_data  (trap_data),
    .trap_hit   (trap_hit),
    .cnt_data   (cnt_data),
    .cnt_hit    (cnt_hit),
    .wr         (wr)
  );

  csr_trap_regs u_trap_regs (
    .clk         (clk),
    .rst         (rst),
    .wr          (wr),
    .effect      (effect),
    .rd_addr     (rd_addr),
    .rd_data     (trap_data),
    .rd_hit      (trap_hit),
    .trap_vector (trap_vector),
    .epc_out     (epc_out),
    .irq_enable  (irq_enable)
  );

  csr_counters u_counters (
    .clk           (clk),
    .rst           (rst),
    .wr            (wr),
    .instret_pulse (instret_pulse),
    .rd_addr       (rd_addr),
    .rd_data       (cnt_data),
    .rd_hit        (cnt_hit)
  );

endmodule

//--- tb_csr_unit.sv
`timescale 1ns/1ns
`include "csr_defs.svh"

module tb_csr_unit;

  localparam int WAIT_LIMIT = 50; // Cycles before a wait gives up

  logic                 clk;
  logic                 rst;
  logic                 req_valid;
  csr_pkg::csr_req_t    req;
  logic                 req_ready;
  logic                 resp_valid;
  csr_pkg::csr_resp_t   resp;
  logic                 resp_ready;
  csr_pkg::csr_effect_t effect;
  logic [`CSR_XLEN-1:0] trap_vector;
  logic [`CSR_XLEN-1:0] epc_out;
  logic                 irq_enable;

  integer seed;
  int     test_errs;
  int     tests_run;
  int     tests_failed;
  bit     aborted;

  csr_unit dut_i (
    .clk         (clk),
    .rst         (rst),
    .req_valid   (req_valid),
    .req         (req),
    .req_ready   (req_ready),
    .resp_valid  (resp_valid),
    .resp        (resp),
    .resp_ready  (resp_ready),
    .effect      (effect),
    .trap_vector (trap_vector),
    .epc_out     (epc_out),
    .irq_enable  (irq_enable)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic check_resp(input csr_pkg::csr_resp_t exp, input csr_pkg::csr_resp_t got,
                            input bit chk_data);
    if (chk_data && got.data !== exp.data) begin
      $display("FAIL %0t resp.data expected %h got %h", $time, exp.data, got.data);
      test_errs++;
    end
    if (got.exists !== exp.exists) begin
      $display("FAIL %0t resp.exists expected %b got %b", $time, exp.exists, got.exists);
      test_errs++;
    end
    if (got.illegal !== exp.illegal) begin
      $display("FAIL %0t resp.illegal expected %b got %b", $time, exp.illegal, got.illegal);
      test_errs++;
    end
  endtask

  task automatic check_word(input string name, input logic [`CSR_XLEN-1:0] exp,
                            input logic [`CSR_XLEN-1:0] got);
    if (got !== exp) begin
      $display("FAIL %0t %s expected %h got %h", $time, name, exp, got);
      test_errs++;
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic got);
    if (got !== exp) begin
      $display("FAIL %0t %s expected %b got %b", $time, name, exp, got);
      test_errs++;
    end
  endtask

  // Both waits start on a falling edge, where outputs are settled
  task automatic wait_req_ready();
    int n;
    n = 0;
    while (!req_ready && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (!req_ready) begin
      $display("Timed out after %0d cycles waiting for req_ready", WAIT_LIMIT);
      aborted = 1'b1;
    end
  endtask

  task automatic wait_resp_valid();
    int n;
    n = 0;
    while (!resp_valid && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (!resp_valid) begin
      $display("Timed out after %0d cycles waiting for resp_valid", WAIT_LIMIT);
      aborted = 1'b1;
    end
  endtask

  // One request, response held back for hold cycles, then consumed
  task automatic run_request(input csr_pkg::csr_req_t r, input int hold,
                             output csr_pkg::csr_resp_t got);
    csr_pkg::csr_resp_t first;
    got = '0;
    @(posedge clk);
    req_valid <= 1'b1;
    req       <= r;
    @(negedge clk);
    wait_req_ready();
    if (!aborted) begin
      @(posedge clk); // Accepting edge
      req_valid <= 1'b0;
      @(negedge clk);
      wait_resp_valid();
      if (!aborted) begin
        first = resp;
        repeat (hold) begin
          @(negedge clk);
          check_bit("req_ready", 1'b0, req_ready);
          check_bit("resp_valid", 1'b1, resp_valid);
          check_resp(first, resp, 1'b1); // Response must not move
        end
        @(posedge clk);
        resp_ready <= 1'b1;
        @(posedge clk); // Consuming edge
        resp_ready <= 1'b0;
        got = first;
      end
    end
  endtask

  task automatic apply_effect(input csr_pkg::csr_effect_t e);
    @(posedge clk);
    effect <= e;
    @(posedge clk);
    effect <= '0;
  endtask

  initial begin
    logic [8*160-1:0]     line;
    integer               fd;
    int                   n;
    int                   hold;
    logic [31:0]          kind;
    logic [31:0]          op;
    logic [31:0]          addr;
    logic [31:0]          data;
    logic [31:0]          cause;
    logic [31:0]          tval;
    logic [31:0]          exp_data;
    logic [31:0]          exp_exists;
    logic [31:0]          exp_ill;
    csr_pkg::csr_req_t    r;
    csr_pkg::csr_resp_t   exp;
    csr_pkg::csr_resp_t   got;
    csr_pkg::csr_effect_t e;

    rst          = 1'b1;
    req_valid    = 1'b0;
    req          = '0;
    resp_ready   = 1'b0;
    effect       = '0;
    seed         = 74;
    tests_run    = 0;
    tests_failed = 0;
    aborted      = 1'b0;

    repeat (10) @(posedge clk);
    rst <= 1'b0;

    fd = $fopen("csr_testdata.txt", "r");
    if (fd == 0) begin
      $display("Could not open csr_testdata.txt");
      aborted = 1'b1;
    end

    while (!aborted && !$feof(fd)) begin
      line = '0;
      n = $fgets(line, fd);
      // Comment and blank lines do not parse to nine fields
      if (n > 0 && $sscanf(line, "%h %h %h %h %h %h %h %h %h", kind, op, addr, data,
                           cause, tval, exp_data, exp_exists, exp_ill) == 9) begin
        test_errs = 0;
        case (kind)
          0, 3, 4: begin
            r.op       = csr_pkg::csr_op_e'(op[1:0]);
            r.addr.raw = addr[11:0];
            r.data     = data;
            hold       = (kind == 3) ? int'(cause) : int'({$random(seed)} % 4);
            run_request(r, hold, got);
            exp.data    = exp_data;
            exp.exists  = exp_exists[0];
            exp.illegal = exp_ill[0];
            if (!aborted)
              check_resp(exp, got, kind != 4);
          end
          1: begin
            e.kind  = csr_pkg::csr_eff_e'(op[1:0]);
            e.epc   = data;
            e.cause = cause;
            e.tval  = tval;
            apply_effect(e);
          end
          2: begin
            @(negedge clk);
            case (op)
              0: check_word("trap_vector", exp_data, trap_vector);
              1: check_word("epc_out", exp_data, epc_out);
              default: check_bit("irq_enable", exp_data[0], irq_enable);
            endcase
          end
          default: begin
            $display("Test data has an unknown kind %0h", kind);
            test_errs++;
          end
        endcase
        tests_run++;
        if (test_errs != 0 || aborted) begin
          tests_failed++;
          $display("test %0d kind %0h addr %h: failed", tests_run, kind, addr[11:0]);
        end else begin
          $display("test %0d kind %0h addr %h: ok", tests_run, kind, addr[11:0]);
        end
      end
    end

    if (fd != 0)
      $fclose(fd);
    $display("%0d tests run, %0d passed, %0d failed", tests_run,
             tests_run - tests_failed, tests_failed);
    if (!aborted && tests_failed == 0 && tests_run > 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

//--- csr_testdata.txt
# kind op addr data cause tval exp_data exp_exists exp_illegal (all hex)
# kind 0 request, 1 effect (op=kind, data=epc), 2 output check, 3 held request, 4 unchecked data
0 0 340 12345678 0 0 00000000 1 0
0 1 340 0f000000 0 0 12345678 1 0
0 2 340 00000078 0 0 1f345678 1 0
0 1 340 00000000 0 0 1f345600 1 0
0 1 301 00000000 0 0 40000100 1 0
0 1 f11 00000000 0 0 00000000 1 0
0 1 f12 00000000 0 0 00000000 1 0
0 1 f13 00000000 0 0 00000000 1 0
0 1 f14 00000000 0 0 00000000 1 0
0 1 7c0 00000000 0 0 00000000 0 1
0 0 f11 00000055 0 0 00000000 1 1
0 1 f11 00000000 0 0 00000000 1 0
0 0 305 00001003 0 0 00000000 1 0
0 1 305 00000000 0 0 00001000 1 0
2 0 000 00000000 0 0 00001000 0 0
0 1 320 00000005 0 0 00000000 1 0
4 0 b00 00abcdef 0 0 00000000 1 0
0 0 b82 00000001 0 0 00000000 1 0
0 1 b00 00000000 0 0 00abcdef 1 0
0 1 b82 00000000 0 0 00000001 1 0
0 1 b02 00000000 0 0 00000000 1 0
0 2 320 00000004 0 0 00000005 1 0
1 1 000 00000000 0 0 00000000 0 0
1 1 000 00000000 0 0 00000000 0 0
1 1 000 00000000 0 0 00000000 0 0
0 1 b02 00000000 0 0 00000003 1 0
0 1 b82 00000000 0 0 00000001 1 0
0 1 b00 00000000 0 0 00abcdef 1 0
0 1 300 00000008 0 0 00000000 1 0
2 2 000 00000000 0 0 00000001 0 0
1 2 000 80000100 b 1234 00000000 0 0
2 1 000 00000000 0 0 80000100 0 0
2 2 000 00000000 0 0 00000000 0 0
0 1 341 00000000 0 0 80000100 1 0
0 1 342 00000000 0 0 0000000b 1 0
0 1 343 00000000 0 0 00001234 1 0
0 1 300 00000000 0 0 00000080 1 0
1 3 000 00000000 0 0 00000000 0 0
2 2 000 00000000 0 0 00000001 0 0
0 1 300 00000000 0 0 00000088 1 0
3 1 340 00000000 5 0 1f345600 1 0

//--- compile.f
+incdir+.
csr_pkg.sv
csr_trap_regs.sv
csr_counters.sv
csr_access.sv
csr_unit.sv
tb_csr_unit.sv

//--- Bender.yml
package:
  name: csr_unit

export_include_dirs:
  - .

sources:
  - files:
      - csr_pkg.sv
      - csr_trap_regs.sv
      - csr_counters.sv
      - csr_access.sv
      - csr_unit.sv
  - target: test
    files:
      - tb_csr_unit.sv
